// File: logic/map_defines.svh
`ifndef MAP_DEFINES_SVH
`define MAP_DEFINES_SVH

// widths
`define MAP_COORD_W 10
`define MAP_ADDR_W 17

// cycles per pixel step
`define MAP_H_STEP 1500000
`define MAP_V_STEP 2000000
`define MAP_MECH_STEP 2000000

// last h_dis that may still step right
`define MAP_H_MAX 282

// lift travel limits
`define MAP_LIFT1_MAX 22
`define MAP_LIFT2_MAX 15

// sprite memory layout
`define MAP_MEM_WIDTH 320
`define MAP_BG_ADDR 12900
`define MAP_BTN_UP_ADDR 540
`define MAP_BTN_DOWN_ADDR 60800

`endif

// File: logic/map_pkg.sv
`include "map_defines.svh"

package map_pkg;

    typedef enum logic [3:0] {
        move_idle  = 4'd6,
        move_right = 4'd7,
        move_left  = 4'd8,
        move_up    = 4'd9
    } move_e;

    typedef enum logic [1:0] {
        jump_none = 2'd0,
        jump_rise = 2'd1,
        jump_fall = 2'd2
    } jump_e;

    typedef struct packed {
        move_e move;
        jump_e jump;
    } player_cmd_t;

    typedef struct packed {
        logic [`MAP_COORD_W-1:0] h_dis;
        logic [`MAP_COORD_W-1:0] v_dis; // grows upward
    } player_pos_t;

    typedef struct packed {
        logic collision;
        logic land;
        logic edge_fall;
    } contact_t;

    typedef struct packed {
        logic                    btn1;
        logic                    btn2;
        logic [`MAP_COORD_W-1:0] lift1;
        logic [`MAP_COORD_W-1:0] lift2;
    } mech_state_t;

    typedef struct packed {
        logic [`MAP_COORD_W-1:0] vga_h;
        logic [`MAP_COORD_W-1:0] vga_v;
    } scan_t;

endpackage

// File: logic/player_motion.sv
`timescale 1ns/1ps
`include "map_defines.svh"

module player_motion #(
    parameter int unsigned h_step = `MAP_H_STEP,
    parameter int unsigned v_step = `MAP_V_STEP
) (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 en,
    input  map_pkg::player_cmd_t cmd,
    input  logic                 collision,
    output map_pkg::player_pos_t pos
);

    localparam int h_cnt_w = $clog2(h_step + 1);
    localparam int v_cnt_w = $clog2(v_step + 1);
    localparam logic [h_cnt_w-1:0] h_last = h_step[h_cnt_w-1:0];
    localparam logic [v_cnt_w-1:0] v_last = v_step[v_cnt_w-1:0];

    logic [h_cnt_w-1:0]      h_cnt;
    logic [v_cnt_w-1:0]      v_cnt;
    logic [`MAP_COORD_W-1:0] h_dis;
    logic [`MAP_COORD_W-1:0] v_dis;
    logic                    go_right;
    logic                    go_left;
    logic                    h_run;
    logic                    v_run;
    logic                    rise;
    logic                    fall;

    assign go_right = (cmd.move == map_pkg::move_right);
    assign go_left  = (cmd.move == map_pkg::move_left);
    assign h_run    = go_right || go_left;
    assign v_run    = h_run || (cmd.move == map_pkg::move_up);
    assign rise     = (cmd.jump == map_pkg::jump_rise);
    assign fall     = (cmd.jump == map_pkg::jump_fall);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            h_cnt <= '0;
            h_dis <= '0;
        end else if (!en) begin
            h_cnt <= '0;
            h_dis <= '0;
        end else if (cmd.move == map_pkg::move_idle) begin
            h_cnt <= '0;
        end else if (h_run) begin
            if (h_cnt == h_last) begin
                h_cnt <= '0;
                if (go_right && h_dis <= `MAP_H_MAX && !collision) begin
                    h_dis <= h_dis + 1'b1;
                end else if (go_left && h_dis != '0 && !collision) begin
                    h_dis <= h_dis - 1'b1;
                end
            end else begin
                h_cnt <= h_cnt + 1'b1;
            end
        end
    end

    // vertical runs under right, left and up; other states hold
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            v_cnt <= '0;
            v_dis <= '0;
        end else if (!en) begin
            v_cnt <= '0;
            v_dis <= '0;
        end else if (v_run) begin
            if (cmd.jump == map_pkg::jump_none) begin
                v_cnt <= '0;
            end else if (rise || fall) begin
                if (v_cnt == v_last) begin
                    v_cnt <= '0;
                    if (rise) begin
                        v_dis <= v_dis + 1'b1;
                    end else if (v_dis != '0) begin // floor clamp
                        v_dis <= v_dis - 1'b1;
                    end
                end else begin
                    v_cnt <= v_cnt + 1'b1;
                end
            end
        end
    end

    assign pos = '{h_dis: h_dis, v_dis: v_dis};

endmodule

// File: logic/map_contacts.sv
`timescale 1ns/1ps

module map_contacts (
    input  map_pkg::player_cmd_t cmd,
    input  map_pkg::player_pos_t pos,
    input  logic                 btn1,
    input  logic                 btn2,
    output map_pkg::contact_t    contact
);

    // sprite edges relative to displacement
    int   h_p8;
    int   h_p10;
    int   h_p13;
    int   h_p22;
    int   h_p25;
    int   h_p28;
    int   head;
    int   feet;
    logic go_right;
    logic go_left;
    logic rise;
    logic fall;
    logic hit_wall1;
    logic hit_right;
    logic hit_wall2;
    logic hit_lift1;
    logic hit_slot;
    logic hit_wall3;
    logic hit_lift2;
    logic on_floor;
    logic on_step;
    logic on_wall1;
    logic on_lift1;
    logic on_wall2;
    logic on_lift2;
    logic on_wall3;

    assign h_p8  = int'(pos.h_dis) + 8;
    assign h_p10 = int'(pos.h_dis) + 10;
    assign h_p13 = int'(pos.h_dis) + 13;
    assign h_p22 = int'(pos.h_dis) + 22;
    assign h_p25 = int'(pos.h_dis) + 25;
    assign h_p28 = int'(pos.h_dis) + 28;
    assign head  = 199 - int'(pos.v_dis);
    assign feet  = 230 - int'(pos.v_dis);

    assign go_right = (cmd.move == map_pkg::move_right);
    assign go_left  = (cmd.move == map_pkg::move_left);
    assign rise     = (cmd.jump == map_pkg::jump_rise);
    assign fall     = (cmd.jump == map_pkg::jump_fall);

    assign hit_wall1 = rise && head == 190 && h_p10 < 240;
    assign hit_right = go_right && h_p28 >= 275 && feet >= 220;
    assign hit_wall2 = rise && head == 147 && h_p10 >= 90;
    assign hit_lift1 = btn1 && go_left && h_p10 <= 40 && feet <= 182 && feet >= 165;
    assign hit_slot  = !btn1 && h_p10 < 40 && head <= 147 && head >= 139; // lift 1 still down
    assign hit_wall3 = rise && head == 104 && h_p10 >= 75 && h_p10 < 270;
    assign hit_lift2 = btn2 && go_right && h_p28 >= 295 && feet >= 130;

    assign on_floor = fall && feet == 230 && h_p28 < 276;
    assign on_step  = fall && h_p13 >= 274 && h_p28 <= 320 && feet == 210;
    assign on_wall1 = fall && feet == 182 && h_p8 >= 8 && h_p25 < 255;
    assign on_lift1 = btn1 && fall && feet == 161 && h_p8 <= 40;
    assign on_wall2 = fall && h_p13 >= 80 && h_p13 < 310 && feet == 139;
    assign on_lift2 = btn2 && fall && feet == 124 && h_p8 >= 295;
    assign on_wall3 = fall && h_p13 >= 85 && h_p13 < 270 && feet == 96;

    assign contact.collision = hit_wall1 || hit_right || hit_wall2 || hit_lift1
                             || hit_slot || hit_wall3 || hit_lift2;

    assign contact.land = on_floor || on_step || on_wall1 || on_lift1
                        || on_wall2 || on_lift2 || on_wall3;

    // walking off one of the five ledges
    assign contact.edge_fall =
        (go_left  && h_p22 <= 277 && feet >= 210 && feet < 212) ||
        (go_right && h_p8  >= 230 && feet >= 182 && feet < 184) ||
        (go_right && h_p8  >= 35  && feet >= 161 && feet < 163) ||
        (go_left  && h_p22 <= 90  && feet >= 137 && feet <= 139) ||
        (go_left  && h_p22 <= 295 && feet >= 122 && feet <= 124);

endmodule

// File: logic/mech_ctrl.sv
`timescale 1ns/1ps
`include "map_defines.svh"

module mech_ctrl #(
    parameter int unsigned mech_step = `MAP_MECH_STEP
) (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 en,
    input  map_pkg::player_pos_t pos1,
    input  map_pkg::player_pos_t pos2,
    output map_pkg::mech_state_t mech
);

    localparam int cnt_w = $clog2(mech_step + 1);
    localparam logic [cnt_w-1:0] cnt_last = mech_step[cnt_w-1:0];

    logic [1:0]                         zone;
    logic [1:0]                         latch;
    logic [1:0][`MAP_COORD_W-1:0]       lift;

    // sprite box overlap with a button strip
    function automatic logic in_zone(input logic [`MAP_COORD_W-1:0] h_dis,
                                     input logic [`MAP_COORD_W-1:0] v_dis,
                                     input int right_off, input int left_off,
                                     input int x_lo, input int x_hi,
                                     input int v_base, input int v_lo, input int v_hi);
        int edge_r;
        int edge_l;
        int v_rel;
        edge_r = int'(h_dis) + right_off;
        edge_l = int'(h_dis) + left_off;
        v_rel  = v_base - int'(v_dis);
        return edge_r >= x_lo && edge_l < x_hi && v_rel >= v_lo && v_rel <= v_hi;
    endfunction

    assign zone[0] = in_zone(pos1.h_dis, pos1.v_dis, 22, 8, 100, 105, 230, 180, 182)
                  || in_zone(pos2.h_dis, pos2.v_dis, 30, 10, 100, 105, 230, 180, 182);
    assign zone[1] = in_zone(pos1.h_dis, pos1.v_dis, 22, 8, 244, 250, 200, 104, 106)
                  || in_zone(pos2.h_dis, pos2.v_dis, 30, 10, 244, 250, 200, 104, 106);

    for (genvar i = 0; i < 2; i++) begin : g_lift
        localparam int lift_max = (i == 0) ? `MAP_LIFT1_MAX : `MAP_LIFT2_MAX;

        logic [cnt_w-1:0]        cnt;
        logic [`MAP_COORD_W-1:0] lift_q;
        logic                    latch_q;

        always_ff @(posedge clk or negedge arst_n) begin
            if (!arst_n) begin
                latch_q <= 1'b0;
                cnt     <= '0;
                lift_q  <= '0;
            end else if (!en) begin
                latch_q <= 1'b0;
                cnt     <= '0;
                lift_q  <= '0;
            end else begin
                if (zone[i]) begin
                    latch_q <= 1'b1; // sticky
                end
                if (!latch_q) begin
                    cnt <= '0;
                end else if (cnt == cnt_last) begin
                    cnt <= '0;
                    if (lift_q < lift_max) begin
                        lift_q <= lift_q + 1'b1;
                    end
                end else begin
                    cnt <= cnt + 1'b1;
                end
            end
        end

        assign latch[i] = latch_q;
        assign lift[i]  = lift_q;
    end

    assign mech = '{btn1: latch[0], btn2: latch[1], lift1: lift[0], lift2: lift[1]};

endmodule

// File: logic/terrain_render.sv
`timescale 1ns/1ps
`include "map_defines.svh"

module terrain_render (
    input  logic                   clk,
    input  logic                   arst_n,
    input  map_pkg::scan_t         scan,
    input  logic                   btn1,
    output logic [`MAP_ADDR_W-1:0] addr
);

    localparam int n_rect = 14;

    // priority order is ceiling, red river, blue river, floor, left, right,
    // walls 1 to 6, red door, blue door
    localparam int rect_h0 [n_rect] = '{0, 150, 210, 0, 0, 310,
                                        10, 90, 85, 160, 110, 275, 250, 280};
    localparam int rect_v0 [n_rect] = '{0, 230, 230, 230, 10, 10,
                                        182, 139, 96, 89, 48, 210, 19, 19};
    localparam int rect_w  [n_rect] = '{320, 40, 40, 320, 10, 10,
                                        230, 220, 185, 50, 200, 35, 23, 23};
    localparam int rect_ht [n_rect] = '{10, 6, 6, 10, 220, 220,
                                        8, 8, 8, 8, 8, 20, 29, 29};
    localparam int rect_mh [n_rect] = '{0, 0, 55, 0, 305, 305,
                                        50, 0, 0, 0, 0, 0, 0, 32};
    localparam int rect_mv [n_rect] = '{220, 65, 70, 220, 10, 10,
                                        215, 220, 220, 220, 220, 218, 89, 89};

    logic [`MAP_COORD_W-1:0] h;
    logic [`MAP_COORD_W-1:0] v;
    logic [`MAP_ADDR_W-1:0]  next_addr;

    assign h = scan.vga_h >> 1; // 320x240 game grid
    assign v = scan.vga_v >> 1;

    always_comb begin
        int lin;
        lin = 0;
        if (h >= 100 && h < 105 && v >= 177 && v < 182) begin
            next_addr = btn1 ? `MAP_ADDR_W'(`MAP_BTN_DOWN_ADDR) : `MAP_ADDR_W'(`MAP_BTN_UP_ADDR);
        end else begin
            next_addr = `MAP_ADDR_W'(`MAP_BG_ADDR);
        end
        // walk backwards so the earliest entry wins
        for (int i = n_rect - 1; i >= 0; i--) begin
            if (int'(h) >= rect_h0[i] && int'(h) < rect_h0[i] + rect_w[i] &&
                int'(v) >= rect_v0[i] && int'(v) < rect_v0[i] + rect_ht[i]) begin
                lin = (rect_mv[i] + int'(v) - rect_v0[i]) * `MAP_MEM_WIDTH
                    + rect_mh[i] + int'(h) - rect_h0[i];
                next_addr = lin[`MAP_ADDR_W-1:0];
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            addr <= `MAP_ADDR_W'(`MAP_BG_ADDR);
        end else begin
            addr <= next_addr;
        end
    end

endmodule

// File: logic/map_top.sv
`timescale 1ns/1ps
`include "map_defines.svh"

module map_top #(
    parameter int unsigned h_step    = `MAP_H_STEP,
    parameter int unsigned v_step    = `MAP_V_STEP,
    parameter int unsigned mech_step = `MAP_MECH_STEP
) (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   en,
    input  map_pkg::player_cmd_t   cmd1,
    input  map_pkg::player_cmd_t   cmd2,
    input  map_pkg::scan_t         scan,
    output map_pkg::player_pos_t   pos1,
    output map_pkg::player_pos_t   pos2,
    output map_pkg::contact_t      contact1,
    output map_pkg::contact_t      contact2,
    output map_pkg::mech_state_t   mech,
    output logic [`MAP_ADDR_W-1:0] addr
);

    player_motion #(.h_step(h_step), .v_step(v_step)) u_motion1 (
        .clk       (clk),
        .arst_n    (arst_n),
        .en        (en),
        .cmd       (cmd1),
        .collision (contact1.collision), // same-player feedback
        .pos       (pos1)
    );

    player_motion #(.h_step(h_step), .v_step(v_step)) u_motion2 (
        .clk       (clk),
        .arst_n    (arst_n),
        .en        (en),
        .cmd       (cmd2),
        .collision (contact2.collision),
        .pos       (pos2)
    );

    map_contacts u_contacts1 (
        .cmd     (cmd1),
        .pos     (pos1),
        .btn1    (mech.btn1),
        .btn2    (mech.btn2),
        .contact (contact1)
    );

    map_contacts u_contacts2 (
        .cmd     (cmd2),
        .pos     (pos2),
        .btn1    (mech.btn1),
        .btn2    (mech.btn2),
        .contact (contact2)
    );

    mech_ctrl #(.mech_step(mech_step)) u_mech (
        .clk    (clk),
        .arst_n (arst_n),
        .en     (en),
        .pos1   (pos1),
        .pos2   (pos2),
        .mech   (mech)
    );

    terrain_render u_render (
        .clk    (clk),
        .arst_n (arst_n),
        .scan   (scan),
        .btn1   (mech.btn1),
        .addr   (addr)
    );

endmodule

// File: verification/map_chk.sv
`timescale 1ns/1ps
`include "map_defines.svh"

module map_chk (
    input logic                 clk,
    input logic                 arst_n,
    input logic                 en,
    input map_pkg::mech_state_t mech
);

    int fail_cnt = 0;

    a_btn1_sticky: assert property (@(posedge clk) disable iff (!arst_n)
        (mech.btn1 && en) |=> mech.btn1)
        else begin
            $error("button 1 latch cleared while enabled");
            fail_cnt++;
        end

    a_btn2_sticky: assert property (@(posedge clk) disable iff (!arst_n)
        (mech.btn2 && en) |=> mech.btn2)
        else begin
            $error("button 2 latch cleared while enabled");
            fail_cnt++;
        end

    a_lift_limit: assert property (@(posedge clk) disable iff (!arst_n)
        mech.lift1 <= `MAP_LIFT1_MAX && mech.lift2 <= `MAP_LIFT2_MAX)
        else begin
            $error("lift offset above its limit");
            fail_cnt++;
        end

    a_lift_parked: assert property (@(posedge clk) disable iff (!arst_n)
        (!mech.btn1 |-> mech.lift1 == 0) and (!mech.btn2 |-> mech.lift2 == 0))
        else begin
            $error("lift moved without its button latch");
            fail_cnt++;
        end

endmodule

bind mech_ctrl map_chk u_chk (
    .clk    (clk),
    .arst_n (arst_n),
    .en     (en),
    .mech   (mech)
);

// File: verification/map_monitor.sv
`timescale 1ns/1ps
`include "map_defines.svh"

module map_monitor (
    input map_pkg::player_pos_t   pos1,
    input map_pkg::player_pos_t   pos2,
    input map_pkg::contact_t      contact1,
    input map_pkg::contact_t      contact2,
    input map_pkg::mech_state_t   mech,
    input logic [`MAP_ADDR_W-1:0] addr
);

    // ceiling, rivers, floor, side walls, walls 1 to 6, doors
    localparam int org_h [14] = '{0, 150, 210, 0, 0, 310, 10, 90, 85, 160, 110, 275, 250, 280};
    localparam int org_v [14] = '{0, 230, 230, 230, 10, 10, 182, 139, 96, 89, 48, 210, 19, 19};
    localparam int size_h [14] = '{320, 40, 40, 320, 10, 10, 230, 220, 185, 50, 200, 35, 23, 23};
    localparam int size_v [14] = '{10, 6, 6, 10, 220, 220, 8, 8, 8, 8, 8, 20, 29, 29};
    localparam int mem_h [14] = '{0, 0, 55, 0, 305, 305, 50, 0, 0, 0, 0, 0, 0, 32};
    localparam int mem_v [14] = '{220, 65, 70, 220, 10, 10, 215, 220, 220, 220, 220, 218, 89, 89};

    int    err_cnt = 0;
    int    test_cnt = 0;
    int    test_errs = 0;
    string test_name;

    function automatic int expected_addr(int vga_h, int vga_v, logic btn);
        int h;
        int v;
        h = vga_h / 2;
        v = vga_v / 2;
        for (int i = 0; i < 14; i++) begin
            if (h >= org_h[i] && h - org_h[i] < size_h[i] &&
                v >= org_v[i] && v - org_v[i] < size_v[i]) begin
                return ((mem_v[i] + v - org_v[i]) * `MAP_MEM_WIDTH + mem_h[i] + h - org_h[i])
                       % (1 << `MAP_ADDR_W);
            end
        end
        if (h >= 100 && h <= 104 && v >= 177 && v <= 181) begin
            return btn ? `MAP_BTN_DOWN_ADDR : `MAP_BTN_UP_ADDR;
        end
        return `MAP_BG_ADDR;
    endfunction

    task automatic compare(string what, int got, int exp);
        if (got != exp) begin
            $display("Error at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
            err_cnt++;
            test_errs++;
        end
    endtask

    task automatic start_test(string name);
        test_name = name;
        test_errs = 0;
        test_cnt++;
    endtask

    task automatic finish_test();
        $display("test %0d %s: %s, %0d errors", test_cnt, test_name,
                 (test_errs == 0) ? "ok" : "bad", test_errs);
    endtask

    task automatic check_row(int row, int exp_h, int exp_v, logic [2:0] exp_contact,
                             logic chk_mech, logic exp_btn, int exp_lift);
        compare($sformatf("row %0d h_dis", row), int'(pos1.h_dis), exp_h);
        compare($sformatf("row %0d v_dis", row), int'(pos1.v_dis), exp_v);
        compare($sformatf("row %0d contact1", row), int'(contact1), int'(exp_contact));
        compare($sformatf("row %0d player 2", row), int'(pos2), 0); // never moved
        compare($sformatf("row %0d contact2", row), int'(contact2), 0);
        if (chk_mech) begin
            compare($sformatf("row %0d btn1", row), int'(mech.btn1), int'(exp_btn));
            compare($sformatf("row %0d btn2", row), int'(mech.btn2), 0);
            compare($sformatf("row %0d lift1", row), int'(mech.lift1), exp_lift);
            compare($sformatf("row %0d lift2", row), int'(mech.lift2), 0);
        end
    endtask

    task automatic check_addr(int vga_h, int vga_v);
        compare($sformatf("addr for scan %0d,%0d", vga_h, vga_v), int'(addr),
                expected_addr(vga_h, vga_v, mech.btn1));
    endtask

    task automatic report();
        $display("%0d tests run, %0d errors", test_cnt, err_cnt);
    endtask

endmodule

// File: verification/map_tb.sv
`timescale 1ns/1ps
`include "map_defines.svh"

module map_tb;

    typedef struct packed {
        map_pkg::move_e move;
        map_pkg::jump_e jump;
        logic           en;
        int unsigned    cycles;
        int unsigned    exp_h;
        int unsigned    exp_v;
        logic [2:0]     exp_contact; // collision, land, edge_fall
        logic           chk_mech;
        logic           exp_btn1;
        int unsigned    exp_lift1;
    } row_t;

    localparam row_t rows [13] = '{
        '{map_pkg::move_idle,  map_pkg::jump_none, 1'b1, 4,    0,   0,  3'b000, 1'b1, 1'b0, 0},
        '{map_pkg::move_right, map_pkg::jump_none, 1'b1, 20,   5,   0,  3'b000, 1'b1, 1'b0, 0},
        '{map_pkg::move_left,  map_pkg::jump_none, 1'b1, 8,    3,   0,  3'b000, 1'b1, 1'b0, 0},
        '{map_pkg::move_left,  map_pkg::jump_none, 1'b1, 24,   0,   0,  3'b000, 1'b1, 1'b0, 0},
        '{map_pkg::move_up,    map_pkg::jump_rise, 1'b1, 40,   0,   10, 3'b000, 1'b1, 1'b0, 0},
        '{map_pkg::move_up,    map_pkg::jump_fall, 1'b1, 16,   0,   6,  3'b000, 1'b1, 1'b0, 0},
        '{map_pkg::move_up,    map_pkg::jump_fall, 1'b1, 40,   0,   0,  3'b010, 1'b1, 1'b0, 0},
        '{map_pkg::move_up,    map_pkg::jump_rise, 1'b1, 80,   0,   20, 3'b000, 1'b1, 1'b0, 0},
        '{map_pkg::move_right, map_pkg::jump_none, 1'b1, 1200, 283, 20, 3'b000, 1'b1, 1'b0, 0},
        '{map_pkg::move_left,  map_pkg::jump_none, 1'b1, 772,  90,  20, 3'b001, 1'b1, 1'b0, 0},
        '{map_pkg::move_up,    map_pkg::jump_rise, 1'b1, 116,  90,  49, 3'b000, 1'b0, 1'b1, 0},
        '{map_pkg::move_idle,  map_pkg::jump_none, 1'b1, 120,  90,  49, 3'b000, 1'b1, 1'b1, 22},
        '{map_pkg::move_idle,  map_pkg::jump_none, 1'b0, 4,    0,   0,  3'b000, 1'b1, 1'b0, 0}
    };

    // fixed scan points for button, ceiling, floor, river, wall 1, right side, open area
    localparam int fixed_h [8] = '{202, 0, 400, 330, 30, 620, 300, 208};
    localparam int fixed_v [8] = '{356, 0, 470, 462, 370, 100, 300, 362};

    logic                   clk;
    logic                   arst_n;
    logic                   en;
    map_pkg::player_cmd_t   cmd1;
    map_pkg::player_cmd_t   cmd2;
    map_pkg::scan_t         scan;
    map_pkg::player_pos_t   pos1;
    map_pkg::player_pos_t   pos2;
    map_pkg::contact_t      contact1;
    map_pkg::contact_t      contact2;
    map_pkg::mech_state_t   mech;
    logic [`MAP_ADDR_W-1:0] addr;
    logic [31:0]            lfsr = 32'h5423;
    bit                     latched;

    map_top #(.h_step(3), .v_step(3), .mech_step(3)) dut (
        .clk      (clk),
        .arst_n   (arst_n),
        .en       (en),
        .cmd1     (cmd1),
        .cmd2     (cmd2),
        .scan     (scan),
        .pos1     (pos1),
        .pos2     (pos2),
        .contact1 (contact1),
        .contact2 (contact2),
        .mech     (mech),
        .addr     (addr)
    );

    map_monitor mon (
        .pos1     (pos1),
        .pos2     (pos2),
        .contact1 (contact1),
        .contact2 (contact2),
        .mech     (mech),
        .addr     (addr)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // taps 32 22 2 1
    function automatic int take_bits(int n);
        logic fb;
        int   val;
        val = 0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            val  = (val << 1) | int'(fb);
        end
        return val;
    endfunction

    task automatic apply_rows(int first, int last);
        for (int r = first; r <= last; r++) begin
            cmd1 = '{move: rows[r].move, jump: rows[r].jump};
            en   = rows[r].en;
            repeat (rows[r].cycles) @(posedge clk);
            #1;
            mon.check_row(r, rows[r].exp_h, rows[r].exp_v, rows[r].exp_contact,
                          rows[r].chk_mech, rows[r].exp_btn1, rows[r].exp_lift1);
        end
    endtask

    task automatic wait_latch(int limit, output bit ok);
        ok = 1'b0;
        for (int i = 0; i < limit && !ok; i++) begin
            if (mech.btn1) begin
                ok = 1'b1;
            end else begin
                @(posedge clk);
                #1;
            end
        end
    endtask

    task automatic probe_scan(int vga_h, int vga_v);
        scan = '{vga_h: vga_h[`MAP_COORD_W-1:0], vga_v: vga_v[`MAP_COORD_W-1:0]};
        @(posedge clk); // addr registers here
        #1;
        mon.check_addr(vga_h, vga_v);
    endtask

    task automatic scan_points();
        int ph;
        int pv;
        for (int i = 0; i < 8; i++) begin
            probe_scan(fixed_h[i], fixed_v[i]);
        end
        for (int i = 0; i < 16; i++) begin
            ph = take_bits(10) % 640;
            pv = take_bits(9) % 480;
            probe_scan(ph, pv);
        end
    endtask

    initial begin
        arst_n = 1'b0;
        en     = 1'b0;
        cmd1   = '{move: map_pkg::move_idle, jump: map_pkg::jump_none};
        cmd2   = '{move: map_pkg::move_idle, jump: map_pkg::jump_none};
        scan   = '0;
        repeat (16) @(posedge clk);
        #1;
        arst_n = 1'b1;
        en     = 1'b1;

        mon.start_test("reset state");
        apply_rows(0, 0);
        mon.finish_test();
        mon.start_test("horizontal stepping");
        apply_rows(1, 3);
        mon.finish_test();
        mon.start_test("jump");
        apply_rows(4, 6);
        mon.finish_test();
        mon.start_test("right bound");
        apply_rows(7, 8);
        mon.finish_test();

        mon.start_test("button and lift");
        apply_rows(9, 10);
        wait_latch(200, latched);
        if (!latched) begin
            $display("timed out waiting for the button 1 latch");
        end
        apply_rows(11, 11);
        mon.finish_test();

        mon.start_test("pixel address, button pressed");
        scan_points();
        mon.finish_test();
        mon.start_test("clear on enable low");
        apply_rows(12, 12);
        en = 1'b1;
        scan_points();
        mon.finish_test();

        mon.report();
        if (mon.err_cnt == 0 && latched && dut.u_mech.u_chk.fail_cnt == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// File: build.f
+incdir+logic
logic/map_pkg.sv
logic/player_motion.sv
logic/map_contacts.sv
logic/mech_ctrl.sv
logic/terrain_render.sv
logic/map_top.sv
verification/map_chk.sv
verification/map_monitor.sv
verification/map_tb.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -Wno-fatal
TOP       ?= map_tb
FILELIST  ?= build.f

OBJ_DIR := obj_dir
SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(wildcard logic/*.sv logic/*.svh verification/*.sv)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM)
	./$(SIM) | tee /dev/stderr | grep -q "Simulation PASSED"

clean:
	rm -rf $(OBJ_DIR)
